// File: hw/mitchell_consts.svh
`ifndef MITCHELL_CONSTS_SVH
`define MITCHELL_CONSTS_SVH

// Operand and log widths.
`define MITCHELL_OPERAND_W 9
`define MITCHELL_FRAC_W 8
`define MITCHELL_CHAR_W 4

`define MITCHELL_PRODUCT_W 18

// Cycles from in_valid to out_valid.
`define MITCHELL_LATENCY 2

`endif

// File: hw/mitchell_pkg.sv
`include "mitchell_consts.svh"

package mitchell_pkg;

    // Two's-complement operand, -256 to 255.
    typedef logic signed [`MITCHELL_OPERAND_W-1:0] operand_t;

    typedef logic [`MITCHELL_CHAR_W-1:0] log_char_t; // Holds 0 to 8.

    // Fraction bits below the leading one, left aligned.
    typedef logic [`MITCHELL_FRAC_W-1:0] log_frac_t;

    typedef logic signed [`MITCHELL_PRODUCT_W-1:0] product_t;

    // One-hot, one place above the leading one.
    typedef logic [`MITCHELL_FRAC_W+1:0] lead_mask_t;

endpackage

// File: hw/leading_oz_detector.sv
`timescale 1ns/10ps

module leading_oz_detector (
    input  logic [7:0]               value,
    input  logic                     sign,
    output mitchell_pkg::log_char_t  leading_one_position,
    output mitchell_pkg::lead_mask_t masked_value
);

    // With sign set, value is magnitude minus one, so an all-ones tail
    // carries into the next position.
    always_comb begin : decode
        casez (value)
            8'b1111_1111: begin
                if (sign) begin
                    leading_one_position = 4'd8;
                    masked_value = 10'b00_0000_0000; // 256 is beyond the table.
                end else begin
                    leading_one_position = 4'd7;
                    masked_value = 10'b01_0000_0000;
                end
            end
            8'b1???_????: begin
                leading_one_position = 4'd7;
                masked_value = 10'b01_0000_0000;
            end
            8'b0111_1111: begin
                leading_one_position = sign ? 4'd7 : 4'd6;
                masked_value = sign ? 10'b01_0000_0000 : 10'b00_1000_0000;
            end
            8'b01??_????: begin
                leading_one_position = 4'd6;
                masked_value = 10'b00_1000_0000;
            end
            8'b0011_1111: begin
                leading_one_position = sign ? 4'd6 : 4'd5;
                masked_value = sign ? 10'b00_1000_0000 : 10'b00_0100_0000;
            end
            8'b001?_????: begin
                leading_one_position = 4'd5;
                masked_value = 10'b00_0100_0000;
            end
            8'b0001_1111: begin
                leading_one_position = sign ? 4'd5 : 4'd4;
                masked_value = sign ? 10'b00_0100_0000 : 10'b00_0010_0000;
            end
            8'b0001_????: begin
                leading_one_position = 4'd4;
                masked_value = 10'b00_0010_0000;
            end
            8'b0000_1111: begin
                leading_one_position = sign ? 4'd4 : 4'd3;
                masked_value = sign ? 10'b00_0010_0000 : 10'b00_0001_0000;
            end
            8'b0000_1???: begin
                leading_one_position = 4'd3;
                masked_value = 10'b00_0001_0000;
            end
            8'b0000_0111: begin
                leading_one_position = sign ? 4'd3 : 4'd2;
                masked_value = sign ? 10'b00_0001_0000 : 10'b00_0000_1000;
            end
            8'b0000_01??: begin
                leading_one_position = 4'd2;
                masked_value = 10'b00_0000_1000;
            end
            8'b0000_0011: begin
                leading_one_position = sign ? 4'd2 : 4'd1;
                masked_value = sign ? 10'b00_0000_1000 : 10'b00_0000_0100;
            end
            8'b0000_001?: begin
                leading_one_position = 4'd1;
                masked_value = 10'b00_0000_0100;
            end
            8'b0000_0001: begin
                leading_one_position = sign ? 4'd1 : 4'd0;
                masked_value = sign ? 10'b00_0000_0100 : 10'b00_0000_0010;
            end
            8'b0000_0000: begin
                // Magnitude one when negative, zero otherwise.
                leading_one_position = 4'd0;
                masked_value = sign ? 10'b00_0000_0010 : 10'b00_0000_0000;
            end
            default: begin
                leading_one_position = 4'd0;
                masked_value = 10'b00_0000_0000;
            end
        endcase
    end

endmodule

// File: hw/log_converter.sv
`timescale 1ns/10ps
`include "mitchell_consts.svh"

module log_converter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  mitchell_pkg::operand_t  operand,
    output logic                    log_valid,
    output logic                    log_sign,
    output logic                    log_zero,
    output mitchell_pkg::log_char_t log_char,
    output mitchell_pkg::log_frac_t log_frac
);

    logic                     op_sign;
    logic [7:0]               ones_value;
    mitchell_pkg::log_char_t  char_pos;
    mitchell_pkg::lead_mask_t lead_mask;
    logic [8:0]               magnitude;
    logic [8:0]               lead_bit;
    logic [8:0]               remainder;
    mitchell_pkg::log_char_t  align_shift;
    logic [8:0]               aligned;

    assign op_sign = operand[`MITCHELL_OPERAND_W-1];
    assign ones_value = op_sign ? ~operand[7:0] : operand[7:0]; // Magnitude minus one if negative.

    leading_oz_detector u_lod (
        .value               (ones_value),
        .sign                (op_sign),
        .leading_one_position(char_pos),
        .masked_value        (lead_mask)
    );

    assign magnitude = op_sign ? {1'b0, ones_value} + 9'd1 : {1'b0, ones_value};

    // Mask shifted down lands on the leading one.
    assign lead_bit = lead_mask[`MITCHELL_FRAC_W+1:1];
    assign remainder = magnitude & ~lead_bit;
    assign align_shift = 4'(`MITCHELL_FRAC_W) - char_pos;
    assign aligned = remainder << align_shift; // Bit 8 of 256 drops out here.

    always_ff @(posedge clk) begin
        if (rst) begin
            log_valid <= 1'b0;
        end else begin
            log_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            log_sign <= op_sign;
            log_zero <= (magnitude == 9'd0);
            log_char <= char_pos;
            log_frac <= aligned[`MITCHELL_FRAC_W-1:0];
        end
    end

    a_char_range : assert property (@(posedge clk) disable iff (rst)
        log_valid |-> log_char <= 4'(`MITCHELL_FRAC_W));

endmodule

// File: hw/antilog_combiner.sv
`timescale 1ns/10ps
`include "mitchell_consts.svh"

module antilog_combiner (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    log_valid,
    input  logic                    a_sign,
    input  logic                    a_zero,
    input  mitchell_pkg::log_char_t a_char,
    input  mitchell_pkg::log_frac_t a_frac,
    input  logic                    b_sign,
    input  logic                    b_zero,
    input  mitchell_pkg::log_char_t b_char,
    input  mitchell_pkg::log_frac_t b_frac,
    output logic                    out_valid,
    output mitchell_pkg::product_t  product
);

    localparam int SCALED_W = `MITCHELL_PRODUCT_W + `MITCHELL_FRAC_W;

    logic [`MITCHELL_CHAR_W:0]  char_sum;
    logic [`MITCHELL_FRAC_W:0]  frac_sum;
    logic                       frac_carry;
    logic [`MITCHELL_FRAC_W:0]  mantissa;
    logic [`MITCHELL_CHAR_W:0]  exponent;
    logic [SCALED_W-1:0]        scaled;
    mitchell_pkg::product_t     magnitude;
    mitchell_pkg::product_t     signed_product;
    logic                       is_zero;
    logic                       negate;

    assign char_sum = {1'b0, a_char} + {1'b0, b_char};
    assign frac_sum = {1'b0, a_frac} + {1'b0, b_frac};
    assign frac_carry = frac_sum[`MITCHELL_FRAC_W];

    // Sum below one gives 1+f at 2^(ka+kb), otherwise f at 2^(ka+kb+1).
    // The carry is the leading one of f, so both cases share one mantissa.
    assign mantissa = {1'b1, frac_sum[`MITCHELL_FRAC_W-1:0]};
    assign exponent = char_sum + {{`MITCHELL_CHAR_W{1'b0}}, frac_carry};

    assign scaled = {{(SCALED_W-`MITCHELL_FRAC_W-1){1'b0}}, mantissa} << exponent;
    assign magnitude = scaled[SCALED_W-1:`MITCHELL_FRAC_W]; // Fraction bits truncated.

    assign is_zero = a_zero | b_zero;
    assign negate = a_sign ^ b_sign;
    assign signed_product = negate ? -magnitude : magnitude;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= log_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (log_valid) begin
            product <= is_zero ? '0 : signed_product;
        end
    end

    // A zero operand must give a zero product on the next cycle.
    a_zero_product : assert property (@(posedge clk) disable iff (rst)
        (log_valid && (a_zero || b_zero)) |=> (out_valid && product == '0));

endmodule

// File: hw/log_multiplier.sv
`timescale 1ns/10ps
`include "mitchell_consts.svh"

module log_multiplier (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  mitchell_pkg::operand_t a,
    input  mitchell_pkg::operand_t b,
    output logic                   out_valid,
    output mitchell_pkg::product_t product
);

    logic                    log_a_valid;
    logic                    log_a_sign;
    logic                    log_a_zero;
    mitchell_pkg::log_char_t log_a_char;
    mitchell_pkg::log_frac_t log_a_frac;

    logic                    log_b_sign;
    logic                    log_b_zero;
    mitchell_pkg::log_char_t log_b_char;
    mitchell_pkg::log_frac_t log_b_frac;

    log_converter u_log_a (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .operand  (a),
        .log_valid(log_a_valid),
        .log_sign (log_a_sign),
        .log_zero (log_a_zero),
        .log_char (log_a_char),
        .log_frac (log_a_frac)
    );

    log_converter u_log_b (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .operand  (b),
        .log_valid(),
        .log_sign (log_b_sign),
        .log_zero (log_b_zero),
        .log_char (log_b_char),
        .log_frac (log_b_frac)
    );

    // Valid is taken from the a side only.
    antilog_combiner u_combine (
        .clk      (clk),
        .rst      (rst),
        .log_valid(log_a_valid),
        .a_sign   (log_a_sign),
        .a_zero   (log_a_zero),
        .a_char   (log_a_char),
        .a_frac   (log_a_frac),
        .b_sign   (log_b_sign),
        .b_zero   (log_b_zero),
        .b_char   (log_b_char),
        .b_frac   (log_b_frac),
        .out_valid(out_valid),
        .product  (product)
    );

    a_latency : assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ##`MITCHELL_LATENCY out_valid);

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period.
    end

endmodule

// File: sim/log_multiplier_tb.sv
`timescale 1ns/10ps
`include "mitchell_consts.svh"

module log_multiplier_tb;

    localparam int RESET_CYCLES = 3;
    localparam int RESULT_TIMEOUT = 20;
    localparam int MAX_GAP = 3;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    mitchell_pkg::operand_t a;
    mitchell_pkg::operand_t b;
    logic                   out_valid;
    mitchell_pkg::product_t product;

    // One entry per operation in flight.
    mitchell_pkg::product_t expected_q[$];
    mitchell_pkg::operand_t a_q[$];
    mitchell_pkg::operand_t b_q[$];
    int                     case_q[$];
    int                     start_q[$];

    int cycle;
    int pass_count;
    int fail_count;
    int result_count;

    tb_clock u_clock (
        .clk(clk)
    );

    log_multiplier dut0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .out_valid(out_valid),
        .product  (product)
    );

    task automatic check_result;
        mitchell_pkg::product_t exp_product;
        mitchell_pkg::operand_t exp_a;
        mitchell_pkg::operand_t exp_b;
        int                     case_id;
        int                     latency;
        if (rst && out_valid) begin
            $display("out_valid went high while rst was asserted");
            fail_count++;
        end else if (out_valid) begin
            if (expected_q.size() == 0) begin
                $display("out_valid went high with no operation in flight");
                fail_count++;
            end else begin
                exp_product = expected_q.pop_front();
                exp_a = a_q.pop_front();
                exp_b = b_q.pop_front();
                case_id = case_q.pop_front();
                latency = cycle - start_q.pop_front();
                result_count++;
                if (product !== exp_product) begin
                    $display("Fail product case %0d: a %h b %h expected %h got %h",
                             case_id, exp_a, exp_b, exp_product, product);
                    fail_count++;
                end else if (latency != `MITCHELL_LATENCY) begin
                    $display("case %0d: result came %0d cycles after in_valid instead of %0d",
                             case_id, latency, `MITCHELL_LATENCY);
                    fail_count++;
                end else begin
                    $display("case %0d ok: a %h b %h product %h",
                             case_id, exp_a, exp_b, product);
                    pass_count++;
                end
            end
        end
    endtask

    // Outputs are stable at the falling edge.
    task automatic next_cycle;
        @(negedge clk);
        cycle++;
        check_result();
    endtask

    initial begin : run
        int          fd;
        int          code;
        int          case_id;
        int          gap;
        int          idle;
        int          prev_results;
        int          run_errors;
        string       line;
        logic [8:0]  a_val;
        logic [8:0]  b_val;
        logic [17:0] p_val;

        rst = 1'b1;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        cycle = 0;
        pass_count = 0;
        fail_count = 0;
        result_count = 0;
        run_errors = 0;
        void'($urandom(84));

        repeat (RESET_CYCLES) next_cycle(); // Three rising edges in reset.
        rst = 1'b0;
        repeat (2) next_cycle();

        fd = $fopen("sim/log_multiplier_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/log_multiplier_vectors.txt");
            run_errors++;
        end else begin
            case_id = 0;
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "/") begin
                    continue; // Blank or comment.
                end
                code = $sscanf(line, "%h %h %h", a_val, b_val, p_val);
                if (code != 3) begin
                    $display("vector line could not be read: %s", line);
                    run_errors++;
                    continue;
                end
                a = a_val;
                b = b_val;
                in_valid = 1'b1;
                expected_q.push_back(p_val);
                a_q.push_back(a_val);
                b_q.push_back(b_val);
                case_q.push_back(case_id);
                start_q.push_back(cycle);
                next_cycle();
                in_valid = 1'b0;
                gap = $urandom % (MAX_GAP + 1); // Zero keeps strobes back to back.
                repeat (gap) next_cycle();
                case_id++;
            end
            $fclose(fd);
        end

        idle = 0;
        prev_results = result_count;
        while (expected_q.size() != 0 && idle < RESULT_TIMEOUT) begin
            next_cycle();
            if (result_count != prev_results) begin
                prev_results = result_count;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (expected_q.size() != 0) begin
            $display("timeout: no out_valid for %0d cycles with %0d results missing",
                     RESULT_TIMEOUT, expected_q.size());
            run_errors++;
        end
        repeat (3) next_cycle(); // Any late out_valid shows up here.

        $display("results: %0d passed, %0d failed", pass_count, fail_count + run_errors);
        if (fail_count == 0 && run_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+hw
hw/mitchell_pkg.sv
hw/leading_oz_detector.sv
hw/log_converter.sv
hw/antilog_combiner.sv
hw/log_multiplier.sv
sim/tb_clock.sv
sim/log_multiplier_tb.sv

// File: Makefile
# Verilator build and run of the Mitchell multiplier testbench.

TOP = log_multiplier_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f all.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: sim/log_multiplier_vectors.txt
// Columns: operand a, operand b, expected product.
// Hex two's complement, 9-bit operands and 18-bit product.
// Powers of two
001 001 00001
080 001 00080
100 002 3fe00
080 080 04000
100 100 10000
040 004 00100
010 008 00080
002 1ff 3fffe
100 001 3ff00
1c0 1fe 00080
// Fraction sums below one
003 005 0000e
005 006 0001c
007 009 0003c
00a 00c 00070
019 025 00370
041 081 020c0
04d 003 000da
005 005 00018
00b 009 00060
0ff 001 000ff
0ff 002 001fe
// Fraction sums of one or more
003 003 00008
0ff 0ff 0fe00
007 007 00030
00f 00f 000e0
07f 07f 03f00
0c8 0c8 09000
064 00d 004c0
03f 01f 007a0
003 007 00014
006 007 00028
// Sign combinations and carries through runs of ones
003 005 0000e
1fd 005 3fff2
003 1fb 3fff2
1fd 1fb 0000e
0c8 025 01b80
138 025 3e480
0c8 1db 3e480
138 1db 01b80
180 064 3ce00
1c0 1ff 00040
1e0 007 3ff20
1f0 1f0 00100
1f8 005 3ffd8
1fc 1fc 00010
1ff 1ff 00001
101 101 0fe00
181 07f 3c100
100 0ff 30100
// Zero on either side
000 000 00000
000 005 00000
1fb 000 00000
000 100 00000
0ff 000 00000
000 1ff 00000
1ff 000 00000
